/* project.f */
tcdm_pkg.sv
stream_pkg.sv
tcdm_if.sv
stream_ctrl.sv
source_streamer.sv
stream_mux.sv
stream_top.sv
tb_tcdm_mem.sv
tb_stream_checker.sv
tb_stream_top.sv

/* Bender.yml */
package:
  name: stream_top

sources:
  - tcdm_pkg.sv
  - stream_pkg.sv
  - tcdm_if.sv
  - stream_ctrl.sv
  - source_streamer.sv
  - stream_mux.sv
  - stream_top.sv
  - target: test
    files:
      - tb_tcdm_mem.sv
      - tb_stream_checker.sv
      - tb_stream_top.sv

/* tb_stream_top.sv */
// Testbench of the read-side streamer
// Runs random jobs on the three load streams against a random-grant memory
module tb_stream_top
  import tcdm_pkg::*;
  import stream_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NumJobs     = 20;
  localparam int unsigned DoneTimeout = 600;

  logic                                       clk_i;
  logic                                       rst_ni;
  logic                                       start;
  logic [NumStreamSources-1:0][AddrWidth-1:0] base;
  logic [NumStreamSources-1:0][LenWidth-1:0]  len;
  logic                                       mem_req;
  logic [AddrWidth-1:0]                       mem_add;
  logic                                       mem_gnt;
  logic                                       mem_r_valid;
  logic [DataWidth-1:0]                       mem_r_data;
  logic [NumStreamSources-1:0]                valid;
  logic [NumStreamSources-1:0][DataWidth-1:0] data;
  logic                                       busy;
  logic                                       done;
  int unsigned                                error_count;
  int unsigned                                check_count;
  integer                                     seed;

  always #20 clk_i = ~clk_i;

  stream_top i_dut (
    .clk_i, .rst_ni, .start_i (start),
    .w_base_i (base[WsourceStreamId]), .x_base_i (base[XsourceStreamId]),
    .y_base_i (base[YsourceStreamId]),
    .w_len_i (len[WsourceStreamId]), .x_len_i (len[XsourceStreamId]),
    .y_len_i (len[YsourceStreamId]),
    .mem_req_o (mem_req), .mem_add_o (mem_add), .mem_gnt_i (mem_gnt),
    .mem_r_valid_i (mem_r_valid), .mem_r_data_i (mem_r_data),
    .w_valid_o (valid[WsourceStreamId]), .w_data_o (data[WsourceStreamId]),
    .x_valid_o (valid[XsourceStreamId]), .x_data_o (data[XsourceStreamId]),
    .y_valid_o (valid[YsourceStreamId]), .y_data_o (data[YsourceStreamId]),
    .busy_o (busy), .done_o (done)
  );

  tb_tcdm_mem i_mem (
    .clk_i, .rst_ni, .req (mem_req), .add (mem_add), .gnt (mem_gnt),
    .r_valid (mem_r_valid), .r_data (mem_r_data)
  );

  tb_stream_checker i_checker (
    .clk_i, .rst_ni, .start, .base, .len, .mem_req, .mem_add, .mem_gnt,
    .mem_r_valid, .valid, .data, .busy, .done, .error_count, .check_count
  );

  task automatic step();
    @(posedge clk_i);
    #2;
  endtask

  // Random lengths 0 to 12 with each stream in its own 64 KiB region
  task automatic pick_job(input int unsigned job);
    for (int s = 0; s < NumStreamSources; s++) begin
      len[s]  = LenWidth'({$random(seed)} % 13);
      base[s] = ((s + 1) << 16) + ({$random(seed)} % 256) * AddrStep;
    end
    if (job == 1) begin
      len = '0;
    end else if (job % 4 == 2) begin
      len[{$random(seed)} % NumStreamSources] = '0;
    end
  endtask

  task automatic run_job(input int unsigned job, output bit finished);
    int unsigned cycles;
    pick_job(job);
    start = 1'b1;
    step();
    start = 1'b0;
    step();
    // A second start lands in the launch cycle and must be ignored
    if (job % 3 == 0) begin
      start = 1'b1;
      for (int s = 0; s < NumStreamSources; s++) begin
        len[s] = LenWidth'({$random(seed)} % 13);
      end
      step();
      start = 1'b0;
    end
    cycles = 0;
    while (!done && cycles < DoneTimeout) begin
      step();
      cycles++;
    end
    finished = done;
    repeat ({$random(seed)} % 3 + 1) step();
  endtask

  initial begin : main
    bit finished;
    bit timed_out;
    seed      = 32'hc35bc97c;
    timed_out = 1'b0;
    rst_ni    = 1'b0;
    start     = 1'b0;
    base      = '0;
    len       = '0;
    clk_i     = 1'b0;
    repeat (8) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    step();
    for (int unsigned job = 0; job < NumJobs; job++) begin
      run_job(job, finished);
      if (!finished) begin
        $display("Timeout: done_o did not pulse in job %0d", job);
        timed_out = 1'b1;
        break;
      end
    end
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (!timed_out && error_count == 0 && check_count > 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* tb_stream_checker.sv */
// Stream checker
// Models the three load streams and compares requests, strobes and control
module tb_stream_checker
  import tcdm_pkg::*;
  import stream_pkg::*;
(
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       start,
  input  logic [NumStreamSources-1:0][AddrWidth-1:0] base,
  input  logic [NumStreamSources-1:0][LenWidth-1:0]  len,
  input  logic                                       mem_req,
  input  logic [AddrWidth-1:0]                       mem_add,
  input  logic                                       mem_gnt,
  input  logic                                       mem_r_valid,
  input  logic [NumStreamSources-1:0]                valid,
  input  logic [NumStreamSources-1:0][DataWidth-1:0] data,
  input  logic                                       busy,
  input  logic                                       done,
  output int unsigned                                error_count,
  output int unsigned                                check_count
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [AddrWidth-1:0] base_q    [NumStreamSources];
  int unsigned          len_q     [NumStreamSources];
  int unsigned          issued    [NumStreamSources];
  int unsigned          delivered [NumStreamSources];
  int                   pending;
  bit                   busy_prev;
  bit                   start_taken;

  function automatic logic [DataWidth-1:0] word_hash(input logic [AddrWidth-1:0] a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h3c6e_f372;
  endfunction

  function automatic string stream_name(input int s);
    case (s)
      WsourceStreamId: return "w";
      XsourceStreamId: return "x";
      default:         return "y";
    endcase
  endfunction

  // Highest-priority stream that still has words to issue
  function automatic int first_open_stream();
    for (int s = 0; s < NumStreamSources; s++) begin
      if (issued[s] < len_q[s]) begin
        return s;
      end
    end
    return -1;
  endfunction

  function automatic logic [AddrWidth-1:0] word_addr(input int s, input int unsigned n);
    return base_q[s] + AddrWidth'(n * AddrStep);
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("[ERROR] %s: got %h expected %h at %0t", name, got, expected, $time);
    end
  endtask

  task automatic report_failure(input string msg);
    error_count++;
    $display("Check failed at %0t: %s", $time, msg);
  endtask

  initial begin
    error_count = 0;
    check_count = 0;
  end

  always @(negedge clk_i) begin : compare
    int                   expected;
    logic                 exp_valid;
    if (!rst_ni) begin
      pending     = -1;
      busy_prev   = 1'b0;
      start_taken = 1'b0;
      for (int s = 0; s < NumStreamSources; s++) begin
        base_q[s]    = '0;
        len_q[s]     = 0;
        issued[s]    = 0;
        delivered[s] = 0;
      end
    end else begin
      // Response of the grant seen one cycle earlier
      for (int s = 0; s < NumStreamSources; s++) begin
        exp_valid = (pending == s) && mem_r_valid;
        compare_value({stream_name(s), "_valid_o"}, valid[s], exp_valid);
        if (valid[s] && exp_valid) begin
          compare_value({stream_name(s), "_data_o"}, data[s],
                        word_hash(word_addr(s, delivered[s])));
          delivered[s]++;
        end
      end
      pending  = -1;
      expected = first_open_stream();
      if (mem_req && expected < 0) begin
        report_failure("mem_req_o is high while no stream has words left");
      end else if (mem_req && mem_gnt) begin
        compare_value("mem_add_o", mem_add, word_addr(expected, issued[expected]));
        issued[expected]++;
        pending = expected;
      end
      if (start_taken && !busy) begin
        report_failure("busy_o did not rise after an accepted start");
      end
      if (busy && !busy_prev && !start_taken) begin
        report_failure("busy_o rose without an accepted start");
      end
      start_taken = 1'b0;
      if (busy_prev && !busy && !done) begin
        report_failure("busy_o fell without a done_o pulse");
      end
      if (done) begin
        if (!busy_prev || busy) begin
          report_failure("done_o pulse does not close a busy period");
        end
        for (int s = 0; s < NumStreamSources; s++) begin
          compare_value({stream_name(s), " words delivered"}, delivered[s], len_q[s]);
        end
      end
      // A start is only taken between jobs
      if (start && !busy) begin
        for (int s = 0; s < NumStreamSources; s++) begin
          base_q[s]    = base[s];
          len_q[s]     = len[s];
          issued[s]    = 0;
          delivered[s] = 0;
        end
        start_taken = 1'b1;
      end
      busy_prev = busy;
    end
  end

endmodule

/* tb_tcdm_mem.sv */
// Memory model for the shared read port
// Grants at random, answers one cycle after each grant with an address hash
module tb_tcdm_mem
  import tcdm_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req,
  input  logic [AddrWidth-1:0] add,
  output logic                 gnt,
  output logic                 r_valid,
  output logic [DataWidth-1:0] r_data
);
  timeunit 1ns;
  timeprecision 1ps;

  integer               seed;
  logic                 granted;
  logic [AddrWidth-1:0] granted_add;

  // Word stored at an address depends on every address bit
  function automatic logic [DataWidth-1:0] word_hash(input logic [AddrWidth-1:0] a);
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h3c6e_f372;
  endfunction

  initial begin
    seed    = 32'hc35bc97c;
    gnt     = 1'b0;
    r_valid = 1'b0;
    r_data  = '0;
  end

  // Port signals are settled mid-cycle
  always @(negedge clk_i) begin
    granted     = rst_ni && req && gnt;
    granted_add = add;
  end

  always @(posedge clk_i) begin
    #2;
    r_valid = granted;
    r_data  = granted ? word_hash(granted_add) : '0;
    gnt     = (($random(seed) & 3) != 0);
  end

endmodule

/* stream_top.sv */
// Read-side streamer top level
// Three load streams W, X and Y sharing one memory port under job control
module stream_top
  import tcdm_pkg::*;
  import stream_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  input  logic [AddrWidth-1:0] w_base_i,
  input  logic [AddrWidth-1:0] x_base_i,
  input  logic [AddrWidth-1:0] y_base_i,
  input  logic [LenWidth-1:0]  w_len_i,
  input  logic [LenWidth-1:0]  x_len_i,
  input  logic [LenWidth-1:0]  y_len_i,
  output logic                 mem_req_o,
  output logic [AddrWidth-1:0] mem_add_o,
  input  logic                 mem_gnt_i,
  input  logic                 mem_r_valid_i,
  input  logic [DataWidth-1:0] mem_r_data_i,
  output logic                 w_valid_o,
  output logic [DataWidth-1:0] w_data_o,
  output logic                 x_valid_o,
  output logic [DataWidth-1:0] x_data_o,
  output logic                 y_valid_o,
  output logic [DataWidth-1:0] y_data_o,
  output logic                 busy_o,
  output logic                 done_o
);

  logic                        clear;
  logic                        stream_start;
  logic [NumStreamSources-1:0] stream_done;
  logic [LenWidth-1:0]         w_len;
  logic [LenWidth-1:0]         x_len;
  logic [LenWidth-1:0]         y_len;

  // Streamer ports, indexed by stream id, and the shared memory port
  tcdm_if src_mem [NumStreamSources] ();
  tcdm_if mem_bus ();

  stream_ctrl i_ctrl (
    .clk_i,
    .rst_ni,
    .start_i,
    .w_len_i,
    .x_len_i,
    .y_len_i,
    .stream_done,
    .w_len_o        (w_len),
    .x_len_o        (x_len),
    .y_len_o        (y_len),
    .clear_o        (clear),
    .stream_start_o (stream_start),
    .busy_o,
    .done_o
  );

  source_streamer i_w_source (
    .clk_i, .rst_ni, .clear_i (clear), .start_i (stream_start),
    .base_i (w_base_i), .len_i (w_len), .mem (src_mem[WsourceStreamId]),
    .word_valid_o (w_valid_o), .word_data_o (w_data_o),
    .done_o (stream_done[WsourceStreamId])
  );

  source_streamer i_x_source (
    .clk_i, .rst_ni, .clear_i (clear), .start_i (stream_start),
    .base_i (x_base_i), .len_i (x_len), .mem (src_mem[XsourceStreamId]),
    .word_valid_o (x_valid_o), .word_data_o (x_data_o),
    .done_o (stream_done[XsourceStreamId])
  );

  source_streamer i_y_source (
    .clk_i, .rst_ni, .clear_i (clear), .start_i (stream_start),
    .base_i (y_base_i), .len_i (y_len), .mem (src_mem[YsourceStreamId]),
    .word_valid_o (y_valid_o), .word_data_o (y_data_o),
    .done_o (stream_done[YsourceStreamId])
  );

  stream_mux i_mux (
    .clk_i,
    .rst_ni,
    .clear_i (clear),
    .in      (src_mem),
    .out     (mem_bus)
  );

  // Shared port out to the memory
  assign mem_req_o       = mem_bus.req;
  assign mem_add_o       = mem_bus.add;
  assign mem_bus.gnt     = mem_gnt_i;
  assign mem_bus.r_valid = mem_r_valid_i;
  assign mem_bus.r_data  = mem_r_data_i;

endmodule

/* stream_mux.sv */
// Fixed-priority stream multiplexer
// Puts the highest-priority requesting stream on the memory port (W, X, Y)
// and routes each response back to the stream granted one cycle earlier
module stream_mux
  import tcdm_pkg::*;
  import stream_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      clear_i,
  tcdm_if.target    in [NumStreamSources],
  tcdm_if.initiator out
);

  localparam logic [StreamIdWidth-1:0] NoWinner = StreamIdWidth'(NumStreamSources);

  logic [NumStreamSources-1:0]                in_req;
  logic [NumStreamSources-1:0]                in_gnt;
  logic [NumStreamSources-1:0][AddrWidth-1:0] in_add;
  logic [StreamIdWidth-1:0]                   winner_d;
  logic [StreamIdWidth-1:0]                   winner_q;
  logic [AddrWidth-1:0]                       out_add;

  always_comb begin : winner_select
    if (in_req[WsourceStreamId]) begin
      winner_d = StreamIdWidth'(WsourceStreamId);
    end else if (in_req[XsourceStreamId]) begin
      winner_d = StreamIdWidth'(XsourceStreamId);
    end else if (in_req[YsourceStreamId]) begin
      winner_d = StreamIdWidth'(YsourceStreamId);
    end else begin
      winner_d = NoWinner;
    end
  end

  // Only one response can be in flight, so the last granted index routes it
  always_ff @(posedge clk_i or negedge rst_ni) begin : winner_register
    if (!rst_ni) begin
      winner_q <= NoWinner;
    end else if (clear_i) begin
      winner_q <= NoWinner;
    end else begin
      winner_q <= (out.req && out.gnt) ? winner_d : NoWinner;
    end
  end

  for (genvar ii = 0; ii < NumStreamSources; ii++) begin : gen_port
    assign in_req[ii]     = in[ii].req;
    assign in_add[ii]     = in[ii].add;
    assign in_gnt[ii]     = (winner_d == StreamIdWidth'(ii)) & out.gnt;
    assign in[ii].gnt     = in_gnt[ii];
    assign in[ii].r_valid = (winner_q == StreamIdWidth'(ii)) & out.r_valid;
    // Data goes to all, the valid strobe picks the owner
    assign in[ii].r_data  = out.r_data;
  end

  always_comb begin : add_select
    out_add = '0;
    for (int unsigned i = 0; i < NumStreamSources; i++) begin
      if (winner_d == StreamIdWidth'(i)) begin
        out_add = in_add[i];
      end
    end
  end

  assign out.req = |in_req;
  assign out.add = out_add;

  one_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(in_gnt))
    else $error("more than one stream granted");

  grant_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (in_gnt & ~in_req) == '0)
    else $error("grant to a stream without request");

endmodule

/* source_streamer.sv */
// Source streamer of one load stream
// Issues len consecutive word reads from base and forwards every response
module source_streamer
  import tcdm_pkg::*;
  import stream_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clear_i,
  input  logic                 start_i,
  input  logic [AddrWidth-1:0] base_i,
  input  logic [LenWidth-1:0]  len_i,
  tcdm_if.initiator            mem,
  output logic                 word_valid_o,
  output logic [DataWidth-1:0] word_data_o,
  output logic                 done_o
);

  logic [AddrWidth-1:0] addr_q;
  logic [LenWidth-1:0]  len_q;
  logic [LenWidth-1:0]  issue_cnt_q;
  logic [LenWidth-1:0]  resp_cnt_q;
  logic [LenWidth-1:0]  resp_cnt_next;
  logic                 done_q;
  logic                 issue;

  // Requests run until every word of the stream has been granted
  assign mem.req       = (issue_cnt_q != len_q);
  assign mem.add       = addr_q;
  assign issue         = mem.req & mem.gnt;
  assign resp_cnt_next = resp_cnt_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin : count_register
    if (!rst_ni) begin
      len_q       <= '0;
      issue_cnt_q <= '0;
      resp_cnt_q  <= '0;
      done_q      <= 1'b0;
    end else if (clear_i) begin
      // Zero length keeps the port quiet until the next start
      len_q       <= '0;
      issue_cnt_q <= '0;
      resp_cnt_q  <= '0;
      done_q      <= 1'b0;
    end else begin
      if (start_i) begin
        len_q  <= len_i;
        done_q <= (len_i == '0);
      end
      if (issue) begin
        issue_cnt_q <= issue_cnt_q + 1'b1;
      end
      if (mem.r_valid) begin
        resp_cnt_q <= resp_cnt_next;
        if (resp_cnt_next == len_q) begin
          done_q <= 1'b1;
        end
      end
    end
  end

  // Address walks forward one word per grant
  always_ff @(posedge clk_i) begin : addr_register
    if (start_i) begin
      addr_q <= base_i;
    end else if (issue) begin
      addr_q <= addr_q + AddrWidth'(AddrStep);
    end
  end

  // Responses need no buffering, the consumer takes every word
  assign word_valid_o = mem.r_valid;
  assign word_data_o  = mem.r_data;
  assign done_o       = done_q;

  req_held_until_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem.req && !mem.gnt |=> mem.req && $stable(mem.add))
    else $error("request dropped or address changed before grant");

endmodule

/* stream_ctrl.sv */
// Job control of the load streamer
// Latches the stream lengths, clears and launches the streamers,
// then waits for all of them and reports the end of the job
module stream_ctrl
  import stream_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        start_i,
  input  logic [LenWidth-1:0]         w_len_i,
  input  logic [LenWidth-1:0]         x_len_i,
  input  logic [LenWidth-1:0]         y_len_i,
  input  logic [NumStreamSources-1:0] stream_done,
  output logic [LenWidth-1:0]         w_len_o,
  output logic [LenWidth-1:0]         x_len_o,
  output logic [LenWidth-1:0]         y_len_o,
  output logic                        clear_o,
  output logic                        stream_start_o,
  output logic                        busy_o,
  output logic                        done_o
);

  enum logic [1:0] {Idle, Clear, Launch, Run} state_d, state_q;

  logic done_d;
  logic done_q;
  logic start_accept;

  // A start is only taken between jobs
  assign start_accept = (state_q == Idle) && start_i;

  always_comb begin : next_state
    state_d = state_q;
    done_d  = 1'b0;
    unique case (state_q)
      Idle: begin
        if (start_i) begin
          state_d = Clear;
        end
      end
      Clear: begin
        state_d = Launch;
      end
      Launch: begin
        state_d = Run;
      end
      Run: begin
        // Done bits were cleared before launch, so they are valid here
        if (&stream_done) begin
          state_d = Idle;
          done_d  = 1'b1;
        end
      end
      default: begin
        state_d = Idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : state_register
    if (!rst_ni) begin
      state_q <= Idle;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin : length_register
    if (start_accept) begin
      w_len_o <= w_len_i;
      x_len_o <= x_len_i;
      y_len_o <= y_len_i;
    end
  end

  assign clear_o        = (state_q == Clear);
  assign stream_start_o = (state_q == Launch);
  assign busy_o         = (state_q != Idle);
  assign done_o         = done_q;

  // The done pulse always closes a job that was running
  done_after_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |-> $past(busy_o))
    else $error("done_o without a running job");

endmodule

/* tcdm_if.sv */
// Memory read port
// Request held until granted, one response exactly one cycle after the grant
interface tcdm_if
  import tcdm_pkg::*;
#(
  parameter int unsigned AW = AddrWidth,
  parameter int unsigned DW = DataWidth
);

  // Request side
  logic          req;
  logic [AW-1:0] add;
  logic          gnt;

  // Response side
  logic          r_valid;
  logic [DW-1:0] r_data;

  modport initiator (
    output req,
    output add,
    input  gnt,
    input  r_valid,
    input  r_data
  );

  modport target (
    input  req,
    input  add,
    output gnt,
    output r_valid,
    output r_data
  );

endinterface

/* stream_pkg.sv */
// Stream package
// Stream identifiers, stream count and the width of a word count
package stream_pkg;

  // Number of load streams, also the "no winner" code of the multiplexer
  localparam int unsigned NumStreamSources = 3;

  // Wide enough to hold every index plus the "no winner" code
  localparam int unsigned StreamIdWidth = $clog2(NumStreamSources + 1);

  // Stream indices, lower index wins arbitration
  localparam int unsigned WsourceStreamId = 0;
  localparam int unsigned XsourceStreamId = 1;
  localparam int unsigned YsourceStreamId = 2;

  // Width of a per-stream word count
  localparam int unsigned LenWidth = 8;

endpackage

/* tcdm_pkg.sv */
// Memory bus package
// Sizes of the shared read port and the address step of a stream
package tcdm_pkg;

  // Byte address and data word width of the memory port
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  // Byte increment between consecutive words of one stream,
  // one full data word per step
  localparam int unsigned AddrStep = DataWidth / 8;

endpackage
